// File: isr_decoder_pkg.sv
package isr_decoder_pkg;

    localparam int ISR_W   = 16;
    localparam int EX_W    = 6;
    localparam int MODE_W  = 2;
    localparam int REG_W   = 3;
    localparam int NREGS   = 8;
    localparam int ALU_W   = 5;
    localparam int SFT_W   = 7;

    typedef logic [ISR_W-1:0]  isr_t;
    typedef logic [EX_W-1:0]   ex_state_t;   // isr[15:10]
    typedef logic [MODE_W-1:0] addr_mode_t;
    typedef logic [REG_W-1:0]  reg_num_t;
    typedef logic [NREGS-1:0]  reg_mask_t;   // bit k selects rk
    typedef logic [ALU_W-1:0]  alu_fn_t;     // {x, y, z, u, v}
    typedef logic [SFT_W-1:0]  sft_t;        // {a, b, c, d, e, r, l}

    // operand addressing modes
    localparam addr_mode_t MODE_D  = 2'd0;
    localparam addr_mode_t MODE_MI = 2'd2;
    localparam addr_mode_t MODE_IP = 2'd3;

    localparam ex_state_t OP_HLT = 6'b000000;
    localparam ex_state_t OP_CLR = 6'b000100;

    localparam ex_state_t OP_ASL = 6'b001000;
    localparam ex_state_t OP_ASR = 6'b001001;
    localparam ex_state_t OP_RLC = 6'b001010;
    localparam ex_state_t OP_RRC = 6'b001011;
    localparam ex_state_t OP_LSL = 6'b001100;
    localparam ex_state_t OP_LSR = 6'b001101;
    localparam ex_state_t OP_ROL = 6'b001110;
    localparam ex_state_t OP_ROR = 6'b001111;

    localparam ex_state_t OP_MOV = 6'b010000;
    localparam ex_state_t OP_JMP = 6'b010001;
    localparam ex_state_t OP_RET = 6'b010010;
    localparam ex_state_t OP_RIT = 6'b010011;
    localparam ex_state_t OP_ADD = 6'b010100;
    localparam ex_state_t OP_RJP = 6'b010101;
    localparam ex_state_t OP_ADC = 6'b010110;
    localparam ex_state_t OP_SUB = 6'b011000;
    localparam ex_state_t OP_SBC = 6'b011010;
    localparam ex_state_t OP_CMP = 6'b011011;

    localparam ex_state_t OP_OR  = 6'b100000;
    localparam ex_state_t OP_XOR = 6'b100001;
    localparam ex_state_t OP_AND = 6'b100010;
    localparam ex_state_t OP_BIT = 6'b100011;

    localparam ex_state_t OP_JSR = 6'b101100;
    localparam ex_state_t OP_RJS = 6'b101101;
    localparam ex_state_t OP_SVC = 6'b101110;

    localparam ex_state_t OP_BRN = 6'b110000;
    localparam ex_state_t OP_BRZ = 6'b110001;
    localparam ex_state_t OP_BRV = 6'b110010;
    localparam ex_state_t OP_BRC = 6'b110011;
    localparam ex_state_t OP_RBN = 6'b111000;
    localparam ex_state_t OP_RBZ = 6'b111001;
    localparam ex_state_t OP_RBV = 6'b111010;
    localparam ex_state_t OP_RBC = 6'b111011;

    localparam logic [3:0] OP_NOP_PREFIX = 4'b0111;   // 0111xx, no control

endpackage

// File: isr_capture.sv
module isr_capture import isr_decoder_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  isr_t       isr,
    input  logic       if0,
    input  logic       if1,
    input  logic       ff0,
    input  logic       ff1,
    input  logic       ff2,
    input  logic       tf0,
    input  logic       tf1,
    input  logic       ex1,
    input  logic       psw_n,
    input  logic       psw_z,
    input  logic       psw_v,
    input  logic       psw_c,
    output ex_state_t  ex_state,
    output addr_mode_t f_mode,
    output addr_mode_t t_mode,
    output reg_num_t   f_reg,
    output reg_num_t   t_reg,
    output logic       if0_q,
    output logic       if1_q,
    output logic       ff0_q,
    output logic       ff1_q,
    output logic       ff2_q,
    output logic       tf0_q,
    output logic       tf1_q,
    output logic       ex1_q,
    output logic       psw_n_q,
    output logic       psw_z_q,
    output logic       psw_v_q,
    output logic       psw_c_q
);

    isr_t isr_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            isr_q <= '0;   // decodes as HLT
            {if0_q, if1_q, ff0_q, ff1_q, ff2_q, tf0_q, tf1_q, ex1_q} <= '0;
            {psw_n_q, psw_z_q, psw_v_q, psw_c_q} <= '0;
        end else begin
            isr_q <= isr;
            {if0_q, if1_q, ff0_q, ff1_q, ff2_q, tf0_q, tf1_q, ex1_q} <=
                {if0, if1, ff0, ff1, ff2, tf0, tf1, ex1};
            {psw_n_q, psw_z_q, psw_v_q, psw_c_q} <= {psw_n, psw_z, psw_v, psw_c};
        end
    end

    // instruction word fields
    assign ex_state = isr_q[15:10];
    assign f_mode   = isr_q[9:8];
    assign f_reg    = isr_q[7:5];
    assign t_mode   = isr_q[4:3];
    assign t_reg    = isr_q[2:0];

endmodule

// File: reg_select_decoder.sv
module reg_select_decoder import isr_decoder_pkg::*; (
    input  ex_state_t  ex_state,
    input  addr_mode_t f_mode,
    input  addr_mode_t t_mode,
    input  reg_num_t   f_reg,
    input  reg_num_t   t_reg,
    input  logic       if0,
    input  logic       if1,
    input  logic       ff0,
    input  logic       ff1,
    input  logic       tf0,
    input  logic       tf1,
    input  logic       ex1,
    input  logic       psw_n,
    input  logic       psw_z,
    input  logic       psw_v,
    input  logic       psw_c,
    output reg_mask_t  reg_read,
    output reg_mask_t  reg_write,
    output logic       b0b,
    output logic       smd,
    output logic       sma
);

    reg_mask_t f_hot;
    reg_mask_t t_hot;
    reg_mask_t r7_only;
    logic      f_is_ip;
    logic      t_is_ip;
    logic      t_is_d;
    logic      op_shift;
    logic      op_arith;
    logic      op_logic;
    logic      op_call;
    logic      op_br;
    logic      op_rb;
    logic      direct_wr;
    logic      taken;
    logic      pc_rd;
    logic      pc_wr;

    assign f_hot   = reg_mask_t'(1) << f_reg;
    assign t_hot   = reg_mask_t'(1) << t_reg;
    assign r7_only = reg_mask_t'(1) << (NREGS - 1);

    assign f_is_ip = (f_mode == MODE_IP);
    assign t_is_ip = (t_mode == MODE_IP);
    assign t_is_d  = (t_mode == MODE_D);

    assign op_shift = (ex_state[5:3] == 3'b001);   // ASL..ROR
    assign op_arith = (ex_state == OP_ADD) | (ex_state == OP_ADC) | (ex_state == OP_RJP) |
                      (ex_state == OP_SUB) | (ex_state == OP_SBC) | (ex_state == OP_CMP);
    assign op_logic = (ex_state == OP_OR) | (ex_state == OP_XOR) | (ex_state == OP_AND);
    assign op_call  = (ex_state == OP_JSR) | (ex_state == OP_RJS) | (ex_state == OP_SVC);
    assign op_br    = (ex_state == OP_BRN) | (ex_state == OP_BRZ) |
                      (ex_state == OP_BRV) | (ex_state == OP_BRC);
    assign op_rb    = (ex_state == OP_RBN) | (ex_state == OP_RBZ) |
                      (ex_state == OP_RBV) | (ex_state == OP_RBC);

    // opcodes that write their result straight into a D-mode t register
    assign direct_wr = (ex_state == OP_CLR) | op_shift | (ex_state == OP_MOV) |
                       (ex_state == OP_ADD) | (ex_state == OP_ADC) |
                       (ex_state == OP_RJP) | op_logic;

    // low two opcode bits pick the flag: n, z, v, c
    always_comb begin
        case (ex_state[1:0])
            2'd0:    taken = psw_n;
            2'd1:    taken = psw_z;
            2'd2:    taken = psw_v;
            default: taken = psw_c;
        endcase
        taken = taken & (op_br | op_rb);
    end

    assign pc_rd = if0 | if1 | ((ex_state == OP_RJS) & ex1);
    assign pc_wr = if1 | (ex_state == OP_JMP) | (ex_state == OP_RET) |
                   (ex_state == OP_RIT) | taken | (op_call & ex1);

    assign reg_read = ({NREGS{ff0}}           & f_hot) |
                      ({NREGS{ff1 & f_is_ip}} & f_hot) |
                      ({NREGS{tf0}}           & t_hot) |
                      ({NREGS{tf1 & t_is_ip}} & t_hot) |
                      ({NREGS{pc_rd}}         & r7_only);

    assign reg_write = ({NREGS{ff0}}                & f_hot) |
                       ({NREGS{ff1 & f_is_ip}}      & f_hot) |
                       ({NREGS{tf1 & t_is_ip}}      & t_hot) |
                       ({NREGS{direct_wr & t_is_d}} & t_hot) |
                       ({NREGS{pc_wr}}              & r7_only);

    assign b0b = (ex_state == OP_MOV) | (ex_state == OP_JMP) | op_arith | op_logic |
                 (ex_state == OP_BIT) | op_call | op_br | op_rb | ex1;

    assign smd = if0 | ff0 | tf0 | (ex_state == OP_CLR) | op_shift | (ex_state == OP_MOV) |
                 (op_arith & (ex_state != OP_CMP)) | op_logic | op_call;

    assign sma = if0 | ff0 | tf0;

endmodule

// File: alu_ctrl_decoder.sv
module alu_ctrl_decoder import isr_decoder_pkg::*; (
    input  ex_state_t  ex_state,
    input  addr_mode_t f_mode,
    input  logic       if0,
    input  logic       if1,
    input  logic       ff0,
    input  logic       ff1,
    input  logic       ff2,
    input  logic       tf0,
    input  logic       tf1,
    input  logic       ex1,
    input  logic       psw_c,
    output alu_fn_t    alu_fn,
    output sft_t       sft,
    output logic       als,
    output logic       mda,
    output logic       shs,
    output logic       sb0,
    output logic       set_psw
);

    logic op_clr, op_mov, op_add, op_adc, op_rjp, op_sub, op_sbc, op_cmp;
    logic op_or, op_xor, op_and, op_bit;
    logic op_asr, op_lsr, op_rol, op_ror, op_rlc, op_rrc;
    logic op_shift;
    logic op_xfer;
    logic op_arith;
    logic op_call;
    logic op_br;
    logic op_rb;
    logic path;

    assign op_clr = (ex_state == OP_CLR);
    assign op_mov = (ex_state == OP_MOV);
    assign op_add = (ex_state == OP_ADD);
    assign op_adc = (ex_state == OP_ADC);
    assign op_rjp = (ex_state == OP_RJP);
    assign op_sub = (ex_state == OP_SUB);
    assign op_sbc = (ex_state == OP_SBC);
    assign op_cmp = (ex_state == OP_CMP);
    assign op_or  = (ex_state == OP_OR);
    assign op_xor = (ex_state == OP_XOR);
    assign op_and = (ex_state == OP_AND);
    assign op_bit = (ex_state == OP_BIT);
    assign op_asr = (ex_state == OP_ASR);
    assign op_lsr = (ex_state == OP_LSR);
    assign op_rol = (ex_state == OP_ROL);
    assign op_ror = (ex_state == OP_ROR);
    assign op_rlc = (ex_state == OP_RLC);
    assign op_rrc = (ex_state == OP_RRC);

    assign op_shift = (ex_state[5:3] == 3'b001);   // all eight shifts
    assign op_xfer  = op_mov | (ex_state == OP_JMP) | (ex_state == OP_RET) |
                      (ex_state == OP_RIT);
    assign op_arith = op_add | op_adc | op_rjp | op_sub | op_sbc | op_cmp;
    assign op_call  = (ex_state == OP_JSR) | (ex_state == OP_RJS) | (ex_state == OP_SVC);
    assign op_br    = (ex_state[5:2] == 4'b1100);
    assign op_rb    = (ex_state[5:2] == 4'b1110);

    // address/pass phases, ff1 is absent here
    assign path = if0 | if1 | ff0 | ff2 | tf0 | tf1 | ex1;

    assign alu_fn[4] = ((f_mode == MODE_MI) & ff0) | op_sub | op_sbc | op_cmp;       // x
    assign alu_fn[3] = path | op_xfer | op_arith | op_call | op_br;                   // y
    assign alu_fn[2] = op_or | op_rb;                                                 // z
    assign alu_fn[1] = if1 | tf1 | (psw_c & (op_adc | op_sbc)) | op_sub | op_cmp;    // u
    assign alu_fn[0] = path | op_xfer | op_arith | op_xor | op_call | op_br | op_rb; // v

    assign als = path | ff1 | op_clr | op_xfer | op_arith | op_or | op_xor | op_and |
                 op_bit | op_call | op_br | op_rb;

    assign mda = ff2 | op_shift | op_arith | op_or | op_xor | op_and | op_bit | op_rb;

    assign shs = op_shift;
    assign sft = {op_asr,
                  op_rol,
                  op_lsr | op_rol | op_rlc,
                  op_ror,
                  op_rlc | op_rrc,
                  op_asr | op_ror | op_rrc,
                  op_asr | op_lsr | op_rol | op_rlc};

    assign sb0 = ff2;

    assign set_psw = op_clr | op_shift | op_mov | op_add | op_adc | op_sub | op_sbc |
                     op_cmp | op_or | op_xor | op_and | op_bit;

endmodule

// File: ctrl_register.sv
module ctrl_register import isr_decoder_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_mask_t reg_read,
    input  reg_mask_t reg_write,
    input  logic      b0b,
    input  logic      smd,
    input  logic      sma,
    input  alu_fn_t   alu_fn,
    input  sft_t      sft,
    input  logic      als,
    input  logic      mda,
    input  logic      shs,
    input  logic      sb0,
    input  logic      set_psw,
    output reg_mask_t reg_read_r,
    output reg_mask_t reg_write_r,
    output logic      b0b_r,
    output logic      smd_r,
    output logic      sma_r,
    output alu_fn_t   alu_fn_r,
    output sft_t      sft_r,
    output logic      als_r,
    output logic      mda_r,
    output logic      shs_r,
    output logic      sb0_r,
    output logic      set_psw_r
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_read_r  <= '0;
            reg_write_r <= '0;
            {b0b_r, smd_r, sma_r} <= '0;
            alu_fn_r    <= '0;
            sft_r       <= '0;
            {als_r, mda_r, shs_r, sb0_r, set_psw_r} <= '0;
        end else begin
            reg_read_r  <= reg_read;
            reg_write_r <= reg_write;
            {b0b_r, smd_r, sma_r} <= {b0b, smd, sma};
            alu_fn_r    <= alu_fn;
            sft_r       <= sft;
            {als_r, mda_r, shs_r, sb0_r, set_psw_r} <= {als, mda, shs, sb0, set_psw};
        end
    end

endmodule

// File: isr_decoder.sv
module isr_decoder import isr_decoder_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  isr_t      isr,
    input  logic      if0,
    input  logic      if1,
    input  logic      ff0,
    input  logic      ff1,
    input  logic      ff2,
    input  logic      tf0,
    input  logic      tf1,
    input  logic      ex1,
    input  logic      psw_n,
    input  logic      psw_z,
    input  logic      psw_v,
    input  logic      psw_c,
    output reg_mask_t reg_read,
    output reg_mask_t reg_write,
    output logic      b0b,
    output logic      smd,
    output logic      sma,
    output alu_fn_t   alu_fn,
    output sft_t      sft,
    output logic      als,
    output logic      mda,
    output logic      shs,
    output logic      sb0,
    output logic      set_psw
);

    ex_state_t  ex_state;
    addr_mode_t f_mode, t_mode;
    reg_num_t   f_reg, t_reg;
    logic       if0_q, if1_q, ff0_q, ff1_q, ff2_q, tf0_q, tf1_q, ex1_q;
    logic       psw_n_q, psw_z_q, psw_v_q, psw_c_q;

    // combinational control word, before the output register
    reg_mask_t  rd_c, wr_c;
    logic       b0b_c, smd_c, sma_c;
    alu_fn_t    alu_fn_c;
    sft_t       sft_c;
    logic       als_c, mda_c, shs_c, sb0_c, set_psw_c;

    isr_capture u_isr_capture (
        .clk, .arst_n, .isr,
        .if0, .if1, .ff0, .ff1, .ff2, .tf0, .tf1, .ex1,
        .psw_n, .psw_z, .psw_v, .psw_c,
        .ex_state, .f_mode, .t_mode, .f_reg, .t_reg,
        .if0_q, .if1_q, .ff0_q, .ff1_q, .ff2_q, .tf0_q, .tf1_q, .ex1_q,
        .psw_n_q, .psw_z_q, .psw_v_q, .psw_c_q
    );

    reg_select_decoder u_reg_select_decoder (
        .ex_state, .f_mode, .t_mode, .f_reg, .t_reg,
        .if0 (if0_q), .if1 (if1_q), .ff0 (ff0_q), .ff1 (ff1_q),
        .tf0 (tf0_q), .tf1 (tf1_q), .ex1 (ex1_q),
        .psw_n (psw_n_q), .psw_z (psw_z_q), .psw_v (psw_v_q), .psw_c (psw_c_q),
        .reg_read (rd_c), .reg_write (wr_c),
        .b0b (b0b_c), .smd (smd_c), .sma (sma_c)
    );

    alu_ctrl_decoder u_alu_ctrl_decoder (
        .ex_state, .f_mode,
        .if0 (if0_q), .if1 (if1_q), .ff0 (ff0_q), .ff1 (ff1_q), .ff2 (ff2_q),
        .tf0 (tf0_q), .tf1 (tf1_q), .ex1 (ex1_q), .psw_c (psw_c_q),
        .alu_fn (alu_fn_c), .sft (sft_c), .als (als_c), .mda (mda_c),
        .shs (shs_c), .sb0 (sb0_c), .set_psw (set_psw_c)
    );

    ctrl_register u_ctrl_register (
        .clk, .arst_n,
        .reg_read (rd_c), .reg_write (wr_c), .b0b (b0b_c), .smd (smd_c), .sma (sma_c),
        .alu_fn (alu_fn_c), .sft (sft_c), .als (als_c), .mda (mda_c),
        .shs (shs_c), .sb0 (sb0_c), .set_psw (set_psw_c),
        .reg_read_r (reg_read), .reg_write_r (reg_write),
        .b0b_r (b0b), .smd_r (smd), .sma_r (sma),
        .alu_fn_r (alu_fn), .sft_r (sft), .als_r (als), .mda_r (mda),
        .shs_r (shs), .sb0_r (sb0), .set_psw_r (set_psw)
    );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: isr_decoder_sva.sv
module isr_decoder_sva import isr_decoder_pkg::*; (
    input logic      clk,
    input logic      arst_n,
    input isr_t      isr,
    input reg_mask_t reg_read,
    input reg_mask_t reg_write,
    input logic      b0b,
    input logic      smd,
    input logic      sma,
    input alu_fn_t   alu_fn,
    input sft_t      sft,
    input logic      als,
    input logic      mda,
    input logic      shs,
    input logic      sb0,
    input logic      set_psw
);

    reset_clear: assert property (@(posedge clk) !arst_n |->
        ({reg_read, reg_write, b0b, smd, sma, alu_fn, sft, als, mda, shs, sb0, set_psw} == '0))
        else $error("control outputs not clear while reset is held");

    no_sb0_on_shift: assert property (@(posedge clk) disable iff (!arst_n) !(sb0 && shs))
        else $error("sb0 and shs set together");

    // r or l only for a shift opcode captured two edges earlier
    dir_outside_shift: assert property (@(posedge clk) disable iff (!arst_n)
        (sft[1] || sft[0]) |-> (shs && $past(isr[15:13], 2) == 3'b001))
        else $error("shift direction bits set without a shift opcode");

endmodule

bind isr_decoder isr_decoder_sva u_isr_decoder_sva (.*);

// File: isr_decoder_tb.sv
module isr_decoder_tb import isr_decoder_pkg::*; ();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 2000;
    localparam int NUM_DIRECTED = 64 * 4 + NREGS * 4;
    localparam int TIMEOUT = (NUM_RANDOM + NUM_DIRECTED + RESET_CYCLES + 20) * CLK_PERIOD;

    typedef logic [35:0] ctrl_word_t;   // {rd, wr, b0b, smd, sma, alu, sft, als, mda, shs, sb0, psw}

    localparam ex_state_t OPS [35] = '{
        OP_HLT, OP_CLR, OP_ASL, OP_ASR, OP_RLC, OP_RRC, OP_LSL, OP_LSR, OP_ROL, OP_ROR,
        OP_MOV, OP_JMP, OP_RET, OP_RIT, OP_ADD, OP_RJP, OP_ADC, OP_SUB, OP_SBC, OP_CMP,
        OP_OR, OP_XOR, OP_AND, OP_BIT, OP_JSR, OP_RJS, OP_SVC,
        OP_BRN, OP_BRZ, OP_BRV, OP_BRC, OP_RBN, OP_RBZ, OP_RBV, OP_RBC};
    localparam logic [7:0] REG_STROBES [4] = '{8'h20, 8'h10, 8'h02, 8'h04};   // ff0 ff1 tf1 tf0

    logic       clk;
    logic       arst_n;
    isr_t       isr;
    logic       if0, if1, ff0, ff1, ff2, tf0, tf1, ex1;
    logic       psw_n, psw_z, psw_v, psw_c;
    reg_mask_t  reg_read, reg_write;
    logic       b0b, smd, sma, als, mda, shs, sb0, set_psw;
    alu_fn_t    alu_fn;
    sft_t       sft;
    ctrl_word_t actual;
    ctrl_word_t expected_q [$];

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_tb_clock_gen (.clk);

    isr_decoder u_isr_decoder (.*);

    assign actual = {reg_read, reg_write, b0b, smd, sma, alu_fn, sft, als, mda, shs, sb0, set_psw};

    function automatic ctrl_word_t expected_ctrl(input isr_t w, input logic [7:0] st,
                                                 input logic [3:0] fl);
        ex_state_t  op;
        addr_mode_t fm, tm;
        reg_num_t   fr, tr;
        logic       if0, if1, ff0, ff1, ff2, tf0, tf1, ex1;
        logic       path, xfer, arith, call, br, rb, shift, taken;
        logic       b0b, smd, sma, als, mda, psw;
        reg_mask_t  rd, wr;
        alu_fn_t    alu;
        sft_t       sf;
        {op, fm, fr, tm, tr} = w;
        {if0, if1, ff0, ff1, ff2, tf0, tf1, ex1} = st;
        shift = op inside {[OP_ASL:OP_ROR]};
        xfer  = op inside {OP_MOV, OP_JMP, OP_RET, OP_RIT};
        arith = op inside {OP_ADD, OP_ADC, OP_RJP, OP_SUB, OP_SBC, OP_CMP};
        call  = op inside {[OP_JSR:OP_SVC]};
        br    = op inside {[OP_BRN:OP_BRC]};
        rb    = op inside {[OP_RBN:OP_RBC]};
        path  = if0 | if1 | ff0 | ff2 | tf0 | tf1 | ex1;
        taken = (br | rb) & fl[2'd3 - op[1:0]];   // fl is {n, z, v, c}
        rd = '0;
        wr = '0;
        if (ff0 || (ff1 && fm == MODE_IP)) begin
            rd[fr] = 1'b1;
            wr[fr] = 1'b1;
        end
        if (tf0 || (tf1 && tm == MODE_IP))
            rd[tr] = 1'b1;
        if ((tf1 && tm == MODE_IP) || (tm == MODE_D && (shift ||
                op inside {OP_CLR, OP_MOV, OP_ADD, OP_ADC, OP_RJP, OP_OR, OP_XOR, OP_AND})))
            wr[tr] = 1'b1;
        if (if0 || if1 || (op == OP_RJS && ex1))
            rd[7] = 1'b1;   // pc is r7
        if (if1 || op inside {OP_JMP, OP_RET, OP_RIT} || taken || (call && ex1))
            wr[7] = 1'b1;
        b0b = ex1 | call | br | rb | arith |
              (op inside {OP_MOV, OP_JMP, OP_OR, OP_XOR, OP_AND, OP_BIT});
        smd = if0 | ff0 | tf0 | shift | call | (op inside {OP_CLR, OP_MOV, OP_ADD, OP_ADC,
                                                           OP_RJP, OP_SUB, OP_SBC, OP_OR,
                                                           OP_XOR, OP_AND});
        sma = if0 | ff0 | tf0;
        alu[4] = (fm == MODE_MI && ff0) || (op inside {OP_SUB, OP_SBC, OP_CMP});
        alu[3] = path | xfer | arith | call | br;
        alu[2] = (op == OP_OR) | rb;
        alu[1] = if1 | tf1 | (fl[0] & (op inside {OP_ADC, OP_SBC})) | (op inside {OP_SUB, OP_CMP});
        alu[0] = path | xfer | arith | (op == OP_XOR) | call | br | rb;
        als = path | ff1 | xfer | arith | call | br | rb |
              (op inside {OP_CLR, OP_OR, OP_XOR, OP_AND, OP_BIT});
        mda = ff2 | shift | arith | rb | (op inside {OP_OR, OP_XOR, OP_AND, OP_BIT});
        psw = shift | (op inside {OP_CLR, OP_MOV, OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CMP,
                                  OP_OR, OP_XOR, OP_AND, OP_BIT});
        case (op)
            OP_ASR:  sf = 7'b1000011;
            OP_RLC:  sf = 7'b0010101;
            OP_RRC:  sf = 7'b0000110;
            OP_LSR:  sf = 7'b0010001;
            OP_ROL:  sf = 7'b0110001;
            OP_ROR:  sf = 7'b0001010;
            default: sf = '0;   // asl and lsl use the plain shifter path
        endcase
        return {rd, wr, b0b, smd, sma, alu, sf, als, mda, shift, ff2, psw};
    endfunction

    task automatic check_word(input ctrl_word_t got, input ctrl_word_t want);
        if (got !== want) begin
            $display("[ERROR] %0t: control word %h, expected %h", $time, got, want);
            $display("TEST FAIL");
            $fatal(1, "control word mismatch");
        end
    endtask

    // compare the word from two edges back, then drive the next set
    task automatic apply_vector(input isr_t w, input logic [7:0] st, input logic [3:0] fl);
        @(posedge clk);
        #1;
        check_word(actual, expected_q.pop_front());
        isr = w;
        {if0, if1, ff0, ff1, ff2, tf0, tf1, ex1} = st;
        {psw_n, psw_z, psw_v, psw_c} = fl;
        expected_q.push_back(expected_ctrl(w, st, fl));
    endtask

    task automatic random_vector();
        isr_t       w;
        int         pick;
        logic [7:0] st;
        w = isr_t'($urandom);
        if ($urandom_range(0, 1) == 1)
            w[15:10] = OPS[$urandom_range(0, $size(OPS) - 1)];
        pick = $urandom_range(0, 8);   // 8 means no strobe
        // shifts have only a t operand, so no f fetch phase
        if (w[15:10] inside {[OP_ASL:OP_ROR]} && pick inside {[2:4]})
            pick = 8;
        st = (pick == 8) ? 8'h00 : 8'h80 >> pick;
        apply_vector(w, st, 4'($urandom_range(0, 15)));
    endtask

    initial begin
        isr = '0;
        {if0, if1, ff0, ff1, ff2, tf0, tf1, ex1} = '0;
        {psw_n, psw_z, psw_v, psw_c} = '0;
        arst_n = 1'b0;
        void'($urandom(32'h424d9297));
        // busy inputs while reset holds the outputs clear
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            check_word(actual, '0);
            isr = isr_t'($urandom);
            {if0, if1, ff0, ff1, ff2, tf0, tf1, ex1} = 8'h80 >> $urandom_range(0, 7);
            {psw_n, psw_z, psw_v, psw_c} = 4'($urandom_range(0, 15));
        end
        isr = '0;
        {if0, if1, ff0, ff1, ff2, tf0, tf1, ex1} = '0;
        {psw_n, psw_z, psw_v, psw_c} = '0;
        arst_n = 1'b1;
        expected_q.push_back('0);   // cleared stages still in flight
        expected_q.push_back('0);
        for (int k = 0; k < NREGS; k++)
            for (int s = 0; s < 4; s++)
                apply_vector({OP_HLT, MODE_IP, reg_num_t'(k), MODE_IP, reg_num_t'(NREGS - 1 - k)},
                             REG_STROBES[s], 4'($urandom_range(0, 15)));
        // every opcode in every t mode with flags alternately low and high
        for (int op = 0; op < 64; op++)
            for (int tm = 0; tm < 4; tm++)
                apply_vector({ex_state_t'(op), addr_mode_t'(3 - tm),
                              reg_num_t'($urandom_range(0, 7)),
                              addr_mode_t'(tm), reg_num_t'($urandom_range(0, 7))},
                             8'h00, {4{tm[0]}});
        repeat (NUM_RANDOM)
            random_vector();
        repeat (2)
            apply_vector('0, '0, '0);
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before all vectors were applied");
        $display("TEST FAIL");
        $fatal(1, "simulation timeout");
    end

endmodule

// File: isr_decoder.f
isr_decoder_pkg.sv
isr_capture.sv
reg_select_decoder.sv
alu_ctrl_decoder.sv
ctrl_register.sv
isr_decoder.sv
tb_clock_gen.sv
isr_decoder_sva.sv
isr_decoder_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f isr_decoder.f --top-module isr_decoder_tb -o isr_decoder_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/isr_decoder_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
